//--- verilog.f
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_lsu_format.sv
hw/rv_core.sv
tb/rv_core_asserts.sv
tb/rv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := rv_core_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- tb/rv_core_tb.sv
`timescale 1ns/1ns

module rv_core_tb import rv_pkg::*; ();

  typedef struct packed {
    word_t      addr;
    word_t      data;
    logic [3:0] strb;
  } store_t;

  logic        clk;
  logic        reset;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp = '0;
  logic        trap;

  word_t       mem [256];
  word_t       prog [$];
  store_t      exp_q [$];
  int          store_idx = 0;
  int          delay_left = -1;
  int          delay = 0;
  logic        random_ready = 1'b0;
  logic [31:0] lfsr = 32'h24cebfe0;

  rv_core i_dut (
    .clk     (clk),
    .reset   (reset),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .trap    (trap)
  );

  bind rv_core rv_core_asserts i_asserts (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // one instruction encoder per format
  function automatic word_t i_type(logic [6:0] opc, logic [2:0] f3, logic [4:0] rd,
                                   logic [4:0] rs1, logic [31:0] imm);
    return {imm[11:0], rs1, f3, rd, opc};
  endfunction

  function automatic word_t r_type(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                   logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic word_t s_type(logic [2:0] f3, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [31:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic word_t b_type(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                   logic [31:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic word_t u_type(logic [6:0] opc, logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic word_t j_type(logic [4:0] rd, logic [31:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic value_error(string name, word_t got, word_t expected);
    fail_run($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, name, got, expected));
  endtask

  task automatic expect_store(word_t addr, word_t data, logic [3:0] strb);
    store_t e;
    e.addr = addr;
    e.data = data;
    e.strb = strb;
    exp_q.push_back(e);
  endtask

  task automatic check_store();
    store_t e;
    assert (store_idx < exp_q.size())
      else fail_run($sformatf("unexpected extra store to address %h", mem_req.addr));
    e = exp_q[store_idx];
    assert (mem_req.instr == 1'b0)
      else value_error("mem_req.instr", {31'b0, mem_req.instr}, 32'd0);
    assert (mem_req.addr == e.addr) else value_error("mem_req.addr", mem_req.addr, e.addr);
    assert (mem_req.wdata == e.data) else value_error("mem_req.wdata", mem_req.wdata, e.data);
    assert (mem_req.wstrb == e.strb)
      else value_error("mem_req.wstrb", {28'b0, mem_req.wstrb}, {28'b0, e.strb});
    store_idx++;
  endtask

  // request is accepted at the next rising edge, so it is served here
  task automatic accept_request();
    int idx;
    idx = int'(mem_req.addr[9:2]);
    mem_rsp.rdata = mem[idx];
    if (mem_req.wstrb != 4'b0000) begin
      check_store();
      for (int b = 0; b < 4; b++) begin
        if (mem_req.wstrb[b]) mem[idx][8*b +: 8] = mem_req.wdata[8*b +: 8];
      end
    end
  endtask

  // memory model with 0 to 3 cycles of ready delay
  always @(negedge clk) begin
    mem_rsp.ready = 1'b0;
    if (mem_req.valid !== 1'b1) begin
      delay_left = -1;
    end else begin
      if (delay_left < 0) begin
        delay = 0;
        if (random_ready) begin
          lfsr = lfsr_next(lfsr);
          delay[0] = lfsr[0];
          lfsr = lfsr_next(lfsr);
          delay[1] = lfsr[0];
        end
      end else begin
        delay = delay_left;
      end
      if (delay == 0) begin
        accept_request();
        mem_rsp.ready = 1'b1;
        delay_left = -1;
      end else begin
        delay_left = delay - 1;
      end
    end
  end

  task automatic wait_request(int limit);
    int n;
    n = 0;
    while (mem_req.valid !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n > limit) fail_run("no memory request appeared after reset");
    end
  endtask

  task automatic wait_trap(int limit);
    int n;
    n = 0;
    while (trap !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n > limit) fail_run("trap did not rise before the timeout");
    end
  endtask

  task automatic check_quiet(int cycles);
    repeat (cycles) begin
      @(negedge clk);
      assert (mem_req.valid == 1'b0)
        else value_error("mem_req.valid", {31'b0, mem_req.valid}, 32'd0);
    end
  endtask

  task automatic check_count(string what);
    assert (store_idx == exp_q.size())
      else fail_run($sformatf("%s stopped after %0d of %0d expected stores",
                              what, store_idx, exp_q.size()));
  endtask

  task automatic run_program(logic rand_mode);
    @(negedge clk);
    reset = 1'b1;
    random_ready = rand_mode;
    store_idx = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'h9e3779b9 * (i + 1);
    end
    foreach (prog[i]) mem[i] = prog[i];
    repeat (16) @(negedge clk);
    assert (mem_req.valid == 1'b0)
      else value_error("mem_req.valid", {31'b0, mem_req.valid}, 32'd0);
    assert (trap == 1'b0) else value_error("trap", {31'b0, trap}, 32'd0);
    reset = 1'b0;
    wait_request(20);
    assert (mem_req.instr == 1'b1)
      else value_error("mem_req.instr", {31'b0, mem_req.instr}, 32'd1);
    assert (mem_req.addr == 32'h0) else value_error("mem_req.addr", mem_req.addr, 32'h0);
    assert (mem_req.wstrb == 4'b0000)
      else value_error("mem_req.wstrb", {28'b0, mem_req.wstrb}, 32'h0);
    wait_trap(5000);
    check_quiet(50);
  endtask

  task automatic load_prog_a();
    prog.delete();
    exp_q.delete();
    prog.push_back(u_type(7'h37, 1, 20'h12345));
    prog.push_back(i_type(7'h13, 3'b000, 1, 1, 32'h678));
    prog.push_back(i_type(7'h13, 3'b000, 10, 0, 256));
    prog.push_back(s_type(3'b010, 1, 10, 0));
    prog.push_back(u_type(7'h17, 2, 20'h00001));
    prog.push_back(s_type(3'b010, 2, 10, 4));
    prog.push_back(i_type(7'h13, 3'b000, 3, 0, -5));
    prog.push_back(i_type(7'h13, 3'b010, 4, 3, 1));
    prog.push_back(i_type(7'h13, 3'b011, 5, 3, 1));
    prog.push_back(i_type(7'h13, 3'b101, 6, 3, 32'h401));
    prog.push_back(i_type(7'h13, 3'b101, 7, 3, 28));
    prog.push_back(r_type(7'h20, 3'b000, 8, 4, 3));
    prog.push_back(r_type(7'h00, 3'b001, 9, 1, 4));
    prog.push_back(r_type(7'h00, 3'b011, 11, 4, 3));
    prog.push_back(s_type(3'b010, 6, 10, 8));
    prog.push_back(s_type(3'b010, 7, 10, 12));
    prog.push_back(s_type(3'b010, 8, 10, 16));
    prog.push_back(s_type(3'b010, 9, 10, 20));
    prog.push_back(i_type(7'h13, 3'b001, 12, 11, 1));
    prog.push_back(r_type(7'h00, 3'b110, 12, 12, 4));
    prog.push_back(r_type(7'h00, 3'b100, 12, 12, 5));
    prog.push_back(s_type(3'b010, 12, 10, 24));
    prog.push_back(i_type(7'h13, 3'b111, 13, 1, 32'h0f0));
    prog.push_back(r_type(7'h20, 3'b101, 14, 3, 8));
    prog.push_back(s_type(3'b010, 13, 10, 28));
    prog.push_back(s_type(3'b010, 14, 10, 32));
    // every wrong path below leaves another marker in x15
    prog.push_back(i_type(7'h13, 3'b000, 15, 0, 32'h11));
    prog.push_back(b_type(3'b000, 4, 11, 8));
    prog.push_back(s_type(3'b010, 0, 10, 36));
    prog.push_back(b_type(3'b100, 4, 3, 8));
    prog.push_back(b_type(3'b101, 4, 3, 8));
    prog.push_back(i_type(7'h13, 3'b000, 15, 0, 32'h22));
    prog.push_back(b_type(3'b110, 4, 3, 8));
    prog.push_back(i_type(7'h13, 3'b000, 15, 0, 32'h33));
    prog.push_back(b_type(3'b111, 4, 3, 8));
    prog.push_back(b_type(3'b001, 4, 5, 8));
    prog.push_back(i_type(7'h13, 3'b000, 15, 0, 32'h44));
    prog.push_back(s_type(3'b010, 15, 10, 36));
    prog.push_back(j_type(16, 8));
    prog.push_back(i_type(7'h13, 3'b000, 15, 0, 32'h55));
    prog.push_back(i_type(7'h13, 3'b000, 17, 0, 173));
    // 173 + 4 with bit 0 cleared lands on word 44
    prog.push_back(i_type(7'h67, 3'b000, 18, 17, 4));
    prog.push_back(i_type(7'h13, 3'b000, 15, 0, 32'h66));
    prog.push_back(i_type(7'h13, 3'b000, 15, 0, 32'h77));
    prog.push_back(s_type(3'b010, 16, 10, 40));
    prog.push_back(s_type(3'b010, 18, 10, 44));
    prog.push_back(s_type(3'b010, 15, 10, 48));
    prog.push_back(s_type(3'b000, 1, 10, 49));
    prog.push_back(s_type(3'b001, 9, 10, 54));
    prog.push_back(i_type(7'h03, 3'b001, 19, 10, 54));
    prog.push_back(i_type(7'h03, 3'b101, 20, 10, 54));
    prog.push_back(i_type(7'h03, 3'b000, 21, 10, 55));
    prog.push_back(i_type(7'h03, 3'b100, 22, 10, 49));
    prog.push_back(i_type(7'h03, 3'b010, 23, 10, 48));
    prog.push_back(s_type(3'b010, 19, 10, 56));
    prog.push_back(s_type(3'b010, 20, 10, 60));
    prog.push_back(s_type(3'b010, 21, 10, 64));
    prog.push_back(s_type(3'b010, 22, 10, 68));
    prog.push_back(s_type(3'b010, 23, 10, 72));
    prog.push_back(32'h00000000);
    expect_store(32'h100, 32'h12345678, 4'hf);
    expect_store(32'h104, 32'h00001010, 4'hf);
    expect_store(32'h108, 32'hfffffffd, 4'hf);
    expect_store(32'h10c, 32'h0000000f, 4'hf);
    expect_store(32'h110, 32'h00000006, 4'hf);
    expect_store(32'h114, 32'h2468acf0, 4'hf);
    expect_store(32'h118, 32'h00000003, 4'hf);
    expect_store(32'h11c, 32'h00000070, 4'hf);
    expect_store(32'h120, 32'hffffffff, 4'hf);
    expect_store(32'h124, 32'h00000011, 4'hf);
    expect_store(32'h128, 32'h0000009c, 4'hf);
    expect_store(32'h12c, 32'h000000a8, 4'hf);
    expect_store(32'h130, 32'h00000011, 4'hf);
    expect_store(32'h130, 32'h78787878, 4'h2);
    expect_store(32'h134, 32'hacf0acf0, 4'hc);
    expect_store(32'h138, 32'hffffacf0, 4'hf);
    expect_store(32'h13c, 32'h0000acf0, 4'hf);
    expect_store(32'h140, 32'hffffffac, 4'hf);
    expect_store(32'h144, 32'h00000078, 4'hf);
    expect_store(32'h148, 32'h00007811, 4'hf);
  endtask

  task automatic load_prog_b();
    prog.delete();
    exp_q.delete();
    prog.push_back(i_type(7'h13, 3'b000, 10, 0, 256));
    prog.push_back(i_type(7'h13, 3'b000, 1, 0, 32'h5a));
    prog.push_back(s_type(3'b010, 1, 10, 0));
    prog.push_back(i_type(7'h03, 3'b010, 2, 10, 2));
    prog.push_back(s_type(3'b010, 2, 10, 4));
    expect_store(32'h100, 32'h0000005a, 4'hf);
  endtask

  initial begin
    reset = 1'b1;
    load_prog_a();
    run_program(1'b0);
    check_count("program A without ready delay");
    run_program(1'b1);
    check_count("program A with random ready delay");
    load_prog_b();
    run_program(1'b1);
    if (store_idx == exp_q.size()) begin
      $display("All checks passed");
      $finish;
    end else begin
      fail_run("misaligned load program stored the wrong number of words");
    end
  end

endmodule

//--- tb/rv_core_asserts.sv
`timescale 1ns/1ns

module rv_core_asserts import rv_pkg::*; (
  input logic     clk,
  input logic     reset,
  input mem_req_t mem_req,
  input mem_rsp_t mem_rsp,
  input logic     trap
);

  // a waiting request keeps all its fields
  hold_fields: assert property (@(posedge clk) disable iff (reset)
      mem_req.valid && !mem_rsp.ready |=> mem_req.valid && $stable(mem_req.instr) &&
      $stable(mem_req.addr) && $stable(mem_req.wdata) && $stable(mem_req.wstrb))
    else $error("request fields changed before acceptance");

  drop_valid: assert property (@(posedge clk) disable iff (reset)
      mem_req.valid && mem_rsp.ready |=> !mem_req.valid)
    else $error("valid still high in the cycle after acceptance");

  trap_sticky: assert property (@(posedge clk) disable iff (reset) trap |=> trap)
    else $error("trap fell without reset");

  trap_quiet: assert property (@(posedge clk) disable iff (reset) trap |-> !mem_req.valid)
    else $error("request valid while trap is high");

endmodule

//--- hw/rv_core.sv
`timescale 1ns/1ns

module rv_core import rv_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  output mem_req_t mem_req,
  input  mem_rsp_t mem_rsp,
  output logic     trap
);

  typedef enum logic [2:0] {
    st_fetch,
    st_wait_fetch,
    st_decode,
    st_execute,
    st_wait_data,
    st_check_pc,
    st_write_back,
    st_halted
  } state_e;

  state_e     state;
  word_t      pc;
  instr_u     ir;
  decoded_t   dec_w;
  decoded_t   dec_q;
  exec_t      ex;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      wb_data;
  word_t      target;
  logic [3:0] st_wstrb;
  word_t      st_wdata;
  word_t      load_data;
  logic       misaligned;

  rv_decoder i_decoder (
    .instr (ir),
    .dec   (dec_w)
  );

  rv_regfile i_regfile (
    .clk      (clk),
    .rs1      (dec_q.rs1),
    .rs2      (dec_q.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (state == st_write_back),
    .rd       (dec_q.rd),
    .rd_data  (wb_data)
  );

  rv_execute i_execute (
    .dec      (dec_q),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .ex       (ex)
  );

  rv_lsu_format i_lsu_format (
    .funct3     (dec_q.funct3),
    .addr       (ex.addr),
    .store_data (rs2_data),
    .rdata      (mem_rsp.rdata),
    .wstrb      (st_wstrb),
    .wdata      (st_wdata),
    .load_data  (load_data),
    .misaligned (misaligned)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_fetch;
      pc <= reset_pc;
      mem_req.valid <= 1'b0;
      trap <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          mem_req.valid <= 1'b1;
          mem_req.instr <= 1'b1;
          mem_req.addr <= pc;
          mem_req.wdata <= '0;
          mem_req.wstrb <= 4'b0000;
          state <= st_wait_fetch;
        end
        st_wait_fetch: begin
          if (mem_rsp.ready) begin
            mem_req.valid <= 1'b0;
            ir <= mem_rsp.rdata;
            state <= st_decode;
          end
        end
        st_decode: begin
          dec_q <= dec_w;
          state <= st_execute;
        end
        st_execute: begin
          case (dec_q.op_class)
            cls_alu: begin
              wb_data <= ex.result;
              pc <= pc + instr_bytes;
              state <= st_write_back;
            end
            cls_branch: begin
              target <= ex.taken ? ex.target : pc + instr_bytes;
              state <= st_check_pc;
            end
            cls_jal, cls_jalr: begin
              target <= ex.target;
              wb_data <= pc + instr_bytes;
              state <= st_check_pc;
            end
            cls_load, cls_store: begin
              if (misaligned) begin
                trap <= 1'b1;
                state <= st_halted;
              end else begin
                // word address, lanes picked by the strobe
                mem_req.valid <= 1'b1;
                mem_req.instr <= 1'b0;
                mem_req.addr <= {ex.addr[xlen-1:2], 2'b00};
                mem_req.wdata <= st_wdata;
                mem_req.wstrb <= (dec_q.op_class == cls_store) ? st_wstrb : 4'b0000;
                state <= st_wait_data;
              end
            end
            // illegal instruction
            default: begin
              trap <= 1'b1;
              state <= st_halted;
            end
          endcase
        end
        st_wait_data: begin
          if (mem_rsp.ready) begin
            mem_req.valid <= 1'b0;
            pc <= pc + instr_bytes;
            if (dec_q.op_class == cls_load) begin
              wb_data <= load_data;
              state <= st_write_back;
            end else begin
              state <= st_fetch;
            end
          end
        end
        st_check_pc: begin
          if (target[1:0] != 2'b00) begin
            trap <= 1'b1;
            state <= st_halted;
          end else begin
            pc <= target;
            state <= (dec_q.op_class == cls_branch) ? st_fetch : st_write_back;
          end
        end
        st_write_back: state <= st_fetch;
        default: state <= st_halted;
      endcase
    end
  end

endmodule

//--- hw/rv_lsu_format.sv
`timescale 1ns/1ns

module rv_lsu_format import rv_pkg::*; (
  input  logic [2:0] funct3,
  input  word_t      addr,
  input  word_t      store_data,
  input  word_t      rdata,
  output logic [3:0] wstrb,
  output word_t      wdata,
  output word_t      load_data,
  output logic       misaligned
);

  logic [1:0] lane;
  word_t      lane_data;

  assign lane = addr[1:0];

  // addressed byte or halfword moved down to bit 0
  assign lane_data = rdata >> {lane, 3'b000};

  always_comb begin
    case (funct3[1:0])
      2'b00: begin
        wstrb = 4'b0001 << lane;
        wdata = {4{store_data[7:0]}};
      end
      2'b01: begin
        wstrb = 4'b0011 << lane;
        wdata = {2{store_data[15:0]}};
      end
      default: begin
        wstrb = 4'b1111;
        wdata = store_data;
      end
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  load_data = {{24{lane_data[7]}}, lane_data[7:0]};
      3'b001:  load_data = {{16{lane_data[15]}}, lane_data[15:0]};
      3'b100:  load_data = {24'b0, lane_data[7:0]};
      3'b101:  load_data = {16'b0, lane_data[15:0]};
      default: load_data = rdata;
    endcase
  end

  assign misaligned = (funct3[1:0] == 2'b01 && lane[0]) ||
                      (funct3[1:0] == 2'b10 && lane != 2'b00);

endmodule

//--- hw/rv_execute.sv
`timescale 1ns/1ns

module rv_execute import rv_pkg::*; (
  input  decoded_t dec,
  input  word_t    pc,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  output exec_t    ex
);

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;
  logic       cond;

  assign op_a = dec.pc_sel ? pc : rs1_data;
  assign op_b = dec.imm_sel ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      alu_add:    ex.result = op_a + op_b;
      alu_sub:    ex.result = op_a - op_b;
      alu_sll:    ex.result = op_a << shamt;
      alu_slt:    ex.result = {31'b0, $signed(op_a) < $signed(op_b)};
      alu_sltu:   ex.result = {31'b0, op_a < op_b};
      alu_xor:    ex.result = op_a ^ op_b;
      alu_srl:    ex.result = op_a >> shamt;
      alu_sra:    ex.result = $signed(op_a) >>> shamt;
      alu_or:     ex.result = op_a | op_b;
      alu_and:    ex.result = op_a & op_b;
      alu_pass_b: ex.result = op_b;
      default:    ex.result = '0;
    endcase
  end

  // branch compare always on the two registers
  always_comb begin
    case (dec.funct3)
      3'b000:  cond = rs1_data == rs2_data;
      3'b001:  cond = rs1_data != rs2_data;
      3'b100:  cond = $signed(rs1_data) < $signed(rs2_data);
      3'b101:  cond = $signed(rs1_data) >= $signed(rs2_data);
      3'b110:  cond = rs1_data < rs2_data;
      default: cond = rs1_data >= rs2_data;
    endcase
  end

  assign ex.taken = (dec.op_class == cls_branch) && cond;

  // load/store address, also the jalr sum
  assign ex.addr = rs1_data + dec.imm;

  assign ex.target = (dec.op_class == cls_jalr) ? {ex.addr[xlen-1:1], 1'b0} : pc + dec.imm;

endmodule

//--- hw/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile import rv_pkg::*; (
  input  logic     clk,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_data,
  output word_t    rs2_data,
  input  logic     we,
  input  reg_idx_t rd,
  input  word_t    rd_data
);

  // x0 has no storage
  word_t regs [1:reg_count-1];

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

//--- hw/rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder import rv_pkg::*; (
  input  instr_u   instr,
  output decoded_t dec
);

  logic    reg_form;
  logic    f7_base;
  logic    f7_alt;
  alu_op_e arith_op;
  logic    arith_ok;

  assign reg_form = instr.r.opcode == opc_op;
  assign f7_base = instr.r.funct7 == 7'b0000000;
  assign f7_alt = instr.r.funct7 == 7'b0100000;

  // shared by op and op_imm
  always_comb begin
    arith_ok = f7_base || !reg_form;
    case (instr.r.funct3)
      3'b000: arith_op = (reg_form && f7_alt) ? alu_sub : alu_add;
      3'b001: arith_op = alu_sll;
      3'b010: arith_op = alu_slt;
      3'b011: arith_op = alu_sltu;
      3'b100: arith_op = alu_xor;
      3'b101: arith_op = f7_alt ? alu_sra : alu_srl;
      3'b110: arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
    // immediate shifts still carry funct7 in the upper imm bits
    if (instr.r.funct3 == 3'b001) begin
      arith_ok = f7_base;
    end else if (instr.r.funct3 == 3'b101 || (reg_form && instr.r.funct3 == 3'b000)) begin
      arith_ok = f7_base || f7_alt;
    end
  end

  always_comb begin
    dec = '0;
    dec.op_class = cls_illegal;
    dec.alu_op = alu_add;
    dec.rd = instr.r.rd;
    dec.rs1 = instr.i.rs1;
    dec.rs2 = instr.r.rs2;
    dec.funct3 = instr.i.funct3;
    case (instr.r.opcode)
      opc_lui: begin
        dec.op_class = cls_alu;
        dec.alu_op = alu_pass_b;
        dec.imm_sel = 1'b1;
        dec.imm = {instr.u.imm_31_12, 12'b0};
      end
      opc_auipc: begin
        dec.op_class = cls_alu;
        dec.pc_sel = 1'b1;
        dec.imm_sel = 1'b1;
        dec.imm = {instr.u.imm_31_12, 12'b0};
      end
      opc_jal: begin
        dec.op_class = cls_jal;
        dec.imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                   instr.j.imm_11, instr.j.imm_10_1, 1'b0};
      end
      opc_jalr: begin
        if (instr.i.funct3 == 3'b000) dec.op_class = cls_jalr;
        dec.imm = {{20{instr.i.imm[11]}}, instr.i.imm};
      end
      opc_branch: begin
        if (instr.b.funct3[2:1] != 2'b01) dec.op_class = cls_branch;
        dec.rd = '0;
        dec.imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                   instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
      end
      opc_load: begin
        // lb lh lw lbu lhu
        if (instr.i.funct3 != 3'b011 && instr.i.funct3[2:1] != 2'b11) begin
          dec.op_class = cls_load;
        end
        dec.imm = {{20{instr.i.imm[11]}}, instr.i.imm};
      end
      opc_store: begin
        if (instr.s.funct3[2] == 1'b0 && instr.s.funct3 != 3'b011) dec.op_class = cls_store;
        dec.rd = '0;
        dec.imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
      end
      opc_op_imm: begin
        if (arith_ok) dec.op_class = cls_alu;
        dec.alu_op = arith_op;
        dec.imm_sel = 1'b1;
        dec.imm = {{20{instr.i.imm[11]}}, instr.i.imm};
      end
      opc_op: begin
        if (arith_ok) dec.op_class = cls_alu;
        dec.alu_op = arith_op;
      end
      default: dec.op_class = cls_illegal;
    endcase
  end

endmodule

//--- hw/rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_count = 32;
  localparam int reg_idx_w = 5;
  localparam logic [xlen-1:0] reset_pc = '0;
  localparam logic [xlen-1:0] instr_bytes = 32'd4;

  typedef logic [reg_idx_w-1:0] reg_idx_t;
  typedef logic [xlen-1:0] word_t;

  // major opcodes, bits 6:0 of the instruction
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [2:0] {
    cls_alu,
    cls_branch,
    cls_jal,
    cls_jalr,
    cls_load,
    cls_store,
    cls_illegal
  } op_class_e;

  // instruction formats, msb first
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_u;

  typedef struct packed {
    op_class_e  op_class;
    alu_op_e    alu_op;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic [2:0] funct3;
    logic       imm_sel;
    logic       pc_sel;
    word_t      imm;
  } decoded_t;

  typedef struct packed {
    word_t result;
    logic  taken;
    word_t target;
    word_t addr;
  } exec_t;

  typedef struct packed {
    logic       valid;
    logic       instr;
    word_t      addr;
    word_t      wdata;
    logic [3:0] wstrb;
  } mem_req_t;

  typedef struct packed {
    logic  ready;
    word_t rdata;
  } mem_rsp_t;

endpackage
